// ==== hw/log_int_fifo.sv ====
`timescale 1ns/1ps

module log_int_fifo
#(
   parameter type payload_t  = logic [7:0],
   parameter int  FIFO_DEPTH = 8
)
(
   input  logic     pop_clk,
   input  logic     pop_rst_n,

   input  logic     push_i,
   input  payload_t data_i,
   output logic     full_o,

   input  logic     pop_i,
   output payload_t data_o,
   output logic     empty_o
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);

   payload_t         mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;

   assign full_o  = (count == FIFO_DEPTH[PTR_W:0]);
   assign empty_o = (count == '0);
   assign data_o  = mem[rd_ptr];

   // storage is written at the tail
   always_ff @(posedge pop_clk)
   begin
      if (push_i)
      begin
         mem[wr_ptr] <= data_i;
      end
   end

   // pointers wrap on their own since the depth is a power of two
   always_ff @(posedge pop_clk or negedge pop_rst_n)
   begin
      if (!pop_rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push_i)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop_i)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push_i, pop_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // overflow would overwrite the oldest entry
   a_no_push_full: assert property (@(posedge pop_clk) disable iff (!pop_rst_n)
      full_o |-> !push_i)
      else $error("push into a full FIFO");

   // underflow would hand out a stale entry
   a_no_pop_empty: assert property (@(posedge pop_clk) disable iff (!pop_rst_n)
      empty_o |-> !pop_i)
      else $error("pop from an empty FIFO");

endmodule

// ==== hw/log_int_mem_target.sv ====
`timescale 1ns/1ps

module log_int_mem_target
#(
   parameter int MEM_WORDS = 256
)
(
   input  logic                               pop_clk,
   input  logic                               pop_rst_n,
   input  logic                               stall_i,

   // request from the slice
   input  logic                               tgt_req_i,
   input  logic [log_int_pkg::ADDR_WIDTH-1:0] tgt_add_i,
   input  logic                               tgt_wen_i,
   input  logic [log_int_pkg::DATA_WIDTH-1:0] tgt_wdata_i,
   input  logic [log_int_pkg::BE_WIDTH-1:0]   tgt_be_i,
   input  logic [log_int_pkg::ID_WIDTH-1:0]   tgt_id_i,
   output logic                               tgt_gnt_o,

   // read response
   output logic                               tgt_r_valid_o,
   output logic [log_int_pkg::DATA_WIDTH-1:0] tgt_r_rdata_o,
   output logic [log_int_pkg::ID_WIDTH-1:0]   tgt_r_id_o
);

   import log_int_pkg::*;

   localparam int IDX_W = $clog2(MEM_WORDS);

   logic [DATA_WIDTH-1:0] mem [MEM_WORDS];
   log_int_req_t          req;
   log_int_resp_t         resp_q;
   logic [IDX_W-1:0]      word_idx;
   logic                  load_grant;
   logic                  store_grant;

   assign req = '{add: tgt_add_i, wen: tgt_wen_i, wdata: tgt_wdata_i, be: tgt_be_i,
                  id: tgt_id_i};

   // stall holds the target off for test back-pressure
   assign tgt_gnt_o = !stall_i;

   assign load_grant  = tgt_req_i && tgt_gnt_o && (req.wen == WEN_LOAD);
   assign store_grant = tgt_req_i && tgt_gnt_o && (req.wen == WEN_STORE);

   // word index wraps at the memory size
   assign word_idx = req.add[BYTE_OFFSET_WIDTH +: IDX_W];

   // stores only touch the enabled bytes
   always_ff @(posedge pop_clk or negedge pop_rst_n)
   begin
      if (!pop_rst_n)
      begin
         for (int w = 0; w < MEM_WORDS; w++)
         begin
            mem[w] <= '0;
         end
      end
      else if (store_grant)
      begin
         for (int b = 0; b < BE_WIDTH; b++)
         begin
            if (req.be[b])
            begin
               mem[word_idx][BYTE_WIDTH*b +: BYTE_WIDTH] <= req.wdata[BYTE_WIDTH*b +: BYTE_WIDTH];
            end
         end
      end
   end

   always_ff @(posedge pop_clk or negedge pop_rst_n)
   begin
      if (!pop_rst_n)
      begin
         tgt_r_valid_o <= 1'b0;
      end
      else
      begin
         tgt_r_valid_o <= load_grant;
      end
   end

   // read data and tag follow the grant by one cycle
   always_ff @(posedge pop_clk)
   begin
      if (load_grant)
      begin
         resp_q <= '{rdata: mem[word_idx], id: req.id};
      end
   end

   assign tgt_r_rdata_o = resp_q.rdata;
   assign tgt_r_id_o    = resp_q.id;

endmodule

// ==== hw/log_int_pkg.sv ====
package log_int_pkg;

   // byte address and data word widths
   localparam int ADDR_WIDTH = 32;
   localparam int DATA_WIDTH = 32;

   // one enable per data byte
   localparam int BYTE_WIDTH = 8;
   localparam int BE_WIDTH   = DATA_WIDTH / BYTE_WIDTH;

   // low address bits that select a byte inside a word
   localparam int BYTE_OFFSET_WIDTH = $clog2(BE_WIDTH);

   // transaction tag carried back with read data
   localparam int ID_WIDTH = 4;

   // wen encoding on the request port
   localparam logic WEN_LOAD  = 1'b1;
   localparam logic WEN_STORE = 1'b0;

   // request of 73 bits as it sits in the buffer
   typedef struct packed
   {
      logic [ADDR_WIDTH-1:0] add;
      logic                  wen;
      logic [DATA_WIDTH-1:0] wdata;
      logic [BE_WIDTH-1:0]   be;
      logic [ID_WIDTH-1:0]   id;
   } log_int_req_t;

   // read response of 36 bits
   typedef struct packed
   {
      logic [DATA_WIDTH-1:0] rdata;
      logic [ID_WIDTH-1:0]   id;
   } log_int_resp_t;

endpackage

// ==== hw/log_int_slice.sv ====
`timescale 1ns/1ps

module log_int_slice
#(
   parameter int FIFO_DEPTH = 8
)
(
   input  logic                             pop_clk,
   input  logic                             pop_rst_n,

   // request port
   input  logic                             req_i,
   input  logic [log_int_pkg::ADDR_WIDTH-1:0] add_i,
   input  logic                             wen_i,
   input  logic [log_int_pkg::DATA_WIDTH-1:0] wdata_i,
   input  logic [log_int_pkg::BE_WIDTH-1:0]   be_i,
   input  logic [log_int_pkg::ID_WIDTH-1:0]   id_i,
   output logic                             gnt_o,

   // toward the target
   output logic                             tgt_req_o,
   output logic [log_int_pkg::ADDR_WIDTH-1:0] tgt_add_o,
   output logic                             tgt_wen_o,
   output logic [log_int_pkg::DATA_WIDTH-1:0] tgt_wdata_o,
   output logic [log_int_pkg::BE_WIDTH-1:0]   tgt_be_o,
   output logic [log_int_pkg::ID_WIDTH-1:0]   tgt_id_o,
   input  logic                             tgt_gnt_i,

   // responses from the target
   input  logic                             tgt_r_valid_i,
   input  logic [log_int_pkg::DATA_WIDTH-1:0] tgt_r_rdata_i,
   input  logic [log_int_pkg::ID_WIDTH-1:0]   tgt_r_id_i,

   // response port
   output logic                             r_valid_o,
   output logic [log_int_pkg::DATA_WIDTH-1:0] r_rdata_o,
   output logic [log_int_pkg::ID_WIDTH-1:0]   r_id_o
);

   import log_int_pkg::*;

   log_int_req_t  push_req;
   log_int_req_t  head_req;
   log_int_resp_t resp_q;
   logic          fifo_full;
   logic          fifo_empty;
   logic          push;
   logic          pop;

   // grant depends only on room in the buffer
   assign gnt_o = !fifo_full;
   assign push  = req_i && gnt_o;
   assign pop   = tgt_req_o && tgt_gnt_i;

   assign push_req = '{add: add_i, wen: wen_i, wdata: wdata_i, be: be_i, id: id_i};

   log_int_fifo
   #(
      .payload_t  ( log_int_req_t ),
      .FIFO_DEPTH ( FIFO_DEPTH    )
   )
   i_req_fifo
   (
      .pop_clk   ( pop_clk    ),
      .pop_rst_n ( pop_rst_n  ),
      .push_i    ( push       ),
      .data_i    ( push_req   ),
      .full_o    ( fifo_full  ),
      .pop_i     ( pop        ),
      .data_o    ( head_req   ),
      .empty_o   ( fifo_empty )
   );

   // head of the queue goes straight to the target
   assign tgt_req_o   = !fifo_empty;
   assign tgt_add_o   = head_req.add;
   assign tgt_wen_o   = head_req.wen;
   assign tgt_wdata_o = head_req.wdata;
   assign tgt_be_o    = head_req.be;
   assign tgt_id_o    = head_req.id;

   always_ff @(posedge pop_clk or negedge pop_rst_n)
   begin
      if (!pop_rst_n)
      begin
         r_valid_o <= 1'b0;
      end
      else
      begin
         r_valid_o <= tgt_r_valid_i;
      end
   end

   // response payload is only loaded when a response comes in
   always_ff @(posedge pop_clk)
   begin
      if (tgt_r_valid_i)
      begin
         resp_q <= '{rdata: tgt_r_rdata_i, id: tgt_r_id_i};
      end
   end

   assign r_rdata_o = resp_q.rdata;
   assign r_id_o    = resp_q.id;

   // a waiting request must not change under the target
   a_tgt_req_stable: assert property (@(posedge pop_clk) disable iff (!pop_rst_n)
      tgt_req_o && !tgt_gnt_i |=> tgt_req_o && $stable(head_req))
      else $error("target request changed before it was granted");

endmodule

// ==== hw/log_int_top.sv ====
`timescale 1ns/1ps

module log_int_top
#(
   parameter int FIFO_DEPTH = 8,
   parameter int MEM_WORDS  = 256
)
(
   input  logic                               pop_clk,
   input  logic                               pop_rst_n,
   input  logic                               stall_i,

   // request port
   input  logic                               req_i,
   input  logic [log_int_pkg::ADDR_WIDTH-1:0] add_i,
   input  logic                               wen_i,
   input  logic [log_int_pkg::DATA_WIDTH-1:0] wdata_i,
   input  logic [log_int_pkg::BE_WIDTH-1:0]   be_i,
   input  logic [log_int_pkg::ID_WIDTH-1:0]   id_i,
   output logic                               gnt_o,

   // response port
   output logic                               r_valid_o,
   output logic [log_int_pkg::DATA_WIDTH-1:0] r_rdata_o,
   output logic [log_int_pkg::ID_WIDTH-1:0]   r_id_o
);

   import log_int_pkg::*;

   // slice to target request
   logic                  tgt_req;
   logic [ADDR_WIDTH-1:0] tgt_add;
   logic                  tgt_wen;
   logic [DATA_WIDTH-1:0] tgt_wdata;
   logic [BE_WIDTH-1:0]   tgt_be;
   logic [ID_WIDTH-1:0]   tgt_id;
   logic                  tgt_gnt;

   // target to slice response
   logic                  tgt_r_valid;
   logic [DATA_WIDTH-1:0] tgt_r_rdata;
   logic [ID_WIDTH-1:0]   tgt_r_id;

   log_int_slice
   #(
      .FIFO_DEPTH ( FIFO_DEPTH )
   )
   i_slice
   (
      .pop_clk       ( pop_clk     ),
      .pop_rst_n     ( pop_rst_n   ),
      .req_i         ( req_i       ),
      .add_i         ( add_i       ),
      .wen_i         ( wen_i       ),
      .wdata_i       ( wdata_i     ),
      .be_i          ( be_i        ),
      .id_i          ( id_i        ),
      .gnt_o         ( gnt_o       ),
      .tgt_req_o     ( tgt_req     ),
      .tgt_add_o     ( tgt_add     ),
      .tgt_wen_o     ( tgt_wen     ),
      .tgt_wdata_o   ( tgt_wdata   ),
      .tgt_be_o      ( tgt_be      ),
      .tgt_id_o      ( tgt_id      ),
      .tgt_gnt_i     ( tgt_gnt     ),
      .tgt_r_valid_i ( tgt_r_valid ),
      .tgt_r_rdata_i ( tgt_r_rdata ),
      .tgt_r_id_i    ( tgt_r_id    ),
      .r_valid_o     ( r_valid_o   ),
      .r_rdata_o     ( r_rdata_o   ),
      .r_id_o        ( r_id_o      )
   );

   log_int_mem_target
   #(
      .MEM_WORDS ( MEM_WORDS )
   )
   i_mem_target
   (
      .pop_clk       ( pop_clk     ),
      .pop_rst_n     ( pop_rst_n   ),
      .stall_i       ( stall_i     ),
      .tgt_req_i     ( tgt_req     ),
      .tgt_add_i     ( tgt_add     ),
      .tgt_wen_i     ( tgt_wen     ),
      .tgt_wdata_i   ( tgt_wdata   ),
      .tgt_be_i      ( tgt_be      ),
      .tgt_id_i      ( tgt_id      ),
      .tgt_gnt_o     ( tgt_gnt     ),
      .tgt_r_valid_o ( tgt_r_valid ),
      .tgt_r_rdata_o ( tgt_r_rdata ),
      .tgt_r_id_o    ( tgt_r_id    )
   );

endmodule

// ==== project.f ====
hw/log_int_pkg.sv
hw/log_int_fifo.sv
hw/log_int_slice.sv
hw/log_int_mem_target.sv
hw/log_int_top.sv
verification/tb_log_int.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_log_int -f project.f -o sim_tb_log_int
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/sim_tb_log_int)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -qF '*** TEST PASSED ***'; then
   exit 0
fi

echo "pass message not found in simulation output"
exit 1

// ==== verification/tb_log_int.sv ====
`timescale 1ns/1ps

module tb_log_int;

   import log_int_pkg::*;

   localparam int FIFO_DEPTH  = 8;
   localparam int MEM_WORDS   = 256;
   localparam int GNT_LIMIT   = 200;
   localparam int DRAIN_LIMIT = 2000;

   logic                  pop_clk;
   logic                  pop_rst_n;
   logic                  stall_i;
   logic                  req_i;
   logic [ADDR_WIDTH-1:0] add_i;
   logic                  wen_i;
   logic [DATA_WIDTH-1:0] wdata_i;
   logic [BE_WIDTH-1:0]   be_i;
   logic [ID_WIDTH-1:0]   id_i;
   logic                  gnt_o;
   logic                  r_valid_o;
   logic [DATA_WIDTH-1:0] r_rdata_o;
   logic [ID_WIDTH-1:0]   r_id_o;

   // reference model memory image and the loads still waiting for data
   logic [DATA_WIDTH-1:0] model_mem [MEM_WORDS];
   logic [DATA_WIDTH-1:0] exp_data_q [$];
   logic [ID_WIDTH-1:0]   exp_id_q [$];

   integer seed = 32'h15b8;
   int     error_count = 0;
   int     errors_at_start;
   int     tests_run = 0;
   int     tests_failed = 0;
   string  test_name;
   logic   rand_stall = 1'b0;

   log_int_top
   #(
      .FIFO_DEPTH ( FIFO_DEPTH ),
      .MEM_WORDS  ( MEM_WORDS  )
   )
   UUT
   (
      .pop_clk   ( pop_clk   ),
      .pop_rst_n ( pop_rst_n ),
      .stall_i   ( stall_i   ),
      .req_i     ( req_i     ),
      .add_i     ( add_i     ),
      .wen_i     ( wen_i     ),
      .wdata_i   ( wdata_i   ),
      .be_i      ( be_i      ),
      .id_i      ( id_i      ),
      .gnt_o     ( gnt_o     ),
      .r_valid_o ( r_valid_o ),
      .r_rdata_o ( r_rdata_o ),
      .r_id_o    ( r_id_o    )
   );

   initial pop_clk = 1'b0;
   always #10 pop_clk = ~pop_clk;

   function automatic logic [31:0] rand_word();
      return $random(seed);
   endfunction

   function automatic int word_index(input logic [ADDR_WIDTH-1:0] add);
      return int'((add >> 2) % MEM_WORDS);
   endfunction

   // enabled bytes come from the new word and the others keep the old value
   function automatic logic [DATA_WIDTH-1:0] merge_bytes(input logic [DATA_WIDTH-1:0] old_word,
                                                         input logic [DATA_WIDTH-1:0] new_word,
                                                         input logic [BE_WIDTH-1:0]   be);
      logic [DATA_WIDTH-1:0] mask;
      mask = '0;
      for (int i = 0; i < BE_WIDTH; i++)
      begin
         if (be[i])
         begin
            mask[8*i +: 8] = 8'hff;
         end
      end
      return (old_word & ~mask) | (new_word & mask);
   endfunction

   // one falling edge where stall_i may flip during mixed traffic
   task automatic next_cycle();
      logic [31:0] r;
      @(negedge pop_clk);
      if (rand_stall)
      begin
         r = rand_word();
         stall_i = r[0];
      end
   endtask

   // gnt_o only moves after a rising edge so its mid-cycle value decides the next edge
   task automatic send_req(input logic wen, input logic [ADDR_WIDTH-1:0] add,
                           input logic [DATA_WIDTH-1:0] wdata, input logic [BE_WIDTH-1:0] be,
                           input logic [ID_WIDTH-1:0] id);
      int waited;
      int widx;
      waited  = 0;
      req_i   = 1'b1;
      add_i   = add;
      wen_i   = wen;
      wdata_i = wdata;
      be_i    = be;
      id_i    = id;
      while (!gnt_o && waited < GNT_LIMIT)
      begin
         next_cycle();
         waited++;
      end
      if (!gnt_o)
      begin
         $display("timeout at %0t: request to address %h was never granted", $time, add);
         error_count++;
      end
      else
      begin
         widx = word_index(add);
         if (wen == WEN_LOAD)
         begin
            exp_data_q.push_back(model_mem[widx]);
            exp_id_q.push_back(id);
         end
         else
         begin
            model_mem[widx] = merge_bytes(model_mem[widx], wdata, be);
         end
         next_cycle();
      end
      req_i = 1'b0;
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_data_q.size() != 0 && waited < DRAIN_LIMIT)
      begin
         next_cycle();
         waited++;
      end
      if (exp_data_q.size() != 0)
      begin
         $display("timeout at %0t: %0d load responses never arrived", $time, exp_data_q.size());
         error_count++;
      end
   endtask

   task automatic begin_test(input string name);
      test_name       = name;
      errors_at_start = error_count;
   endtask

   task automatic end_test();
      tests_run++;
      if (error_count == errors_at_start)
      begin
         $display("test %0d %s: passed", tests_run, test_name);
      end
      else
      begin
         tests_failed++;
         $display("test %0d %s: failed, %0d errors", tests_run, test_name,
                  error_count - errors_at_start);
      end
   endtask

   // responses arrive in request order so the queue head is the one to match
   always @(posedge pop_clk)
   begin
      if (pop_rst_n && r_valid_o)
      begin
         if (exp_data_q.size() == 0)
         begin
            $display("error at %0t: response with id %h arrived with no load outstanding",
                     $time, r_id_o);
            error_count++;
         end
         else
         begin
            if (r_rdata_o !== exp_data_q[0])
            begin
               $display("[FAIL] %0t: rdata %h, expected %h", $time, r_rdata_o, exp_data_q[0]);
               error_count++;
            end
            if (r_id_o !== exp_id_q[0])
            begin
               $display("[FAIL] %0t: id %h, expected %h", $time, r_id_o, exp_id_q[0]);
               error_count++;
            end
            exp_data_q.delete(0);
            exp_id_q.delete(0);
         end
      end
   end

   initial
   begin
      logic [ADDR_WIDTH-1:0] addr_list [16];
      logic [31:0]           r_add;
      logic [31:0]           r_data;
      logic [31:0]           r_ctl;
      int                    i;
      int                    accepted;
      pop_rst_n = 1'b0;
      stall_i   = 1'b0;
      req_i     = 1'b0;
      add_i     = '0;
      wen_i     = WEN_LOAD;
      wdata_i   = '0;
      be_i      = '0;
      id_i      = '0;
      for (i = 0; i < MEM_WORDS; i++)
      begin
         model_mem[i] = '0;
      end
      repeat (16) @(negedge pop_clk);
      pop_rst_n = 1'b1;

      begin_test("reset state");
      if (gnt_o !== 1'b1)
      begin
         $display("[FAIL] %0t: gnt_o is %b after reset", $time, gnt_o);
         error_count++;
      end
      for (i = 0; i < 20; i++)
      begin
         next_cycle();
         if (r_valid_o !== 1'b0)
         begin
            $display("[FAIL] %0t: r_valid_o is %b while idle", $time, r_valid_o);
            error_count++;
         end
      end
      end_test();

      begin_test("store then load");
      for (i = 0; i < 16; i++)
      begin
         addr_list[i] = rand_word();
         r_data       = rand_word();
         r_ctl        = rand_word();
         send_req(WEN_STORE, addr_list[i], r_data, 4'hf, r_ctl[ID_WIDTH-1:0]);
      end
      for (i = 0; i < 16; i++)
      begin
         r_ctl = rand_word();
         send_req(WEN_LOAD, addr_list[i], '0, '0, r_ctl[ID_WIDTH-1:0]);
      end
      wait_drain();
      end_test();

      begin_test("byte enable merge");
      r_add = rand_word();
      for (i = 0; i < 8; i++)
      begin
         r_data = rand_word();
         r_ctl  = rand_word();
         send_req(WEN_STORE, r_add, r_data, r_ctl[3:0], r_ctl[7:4]);
         send_req(WEN_LOAD, r_add, '0, '0, r_ctl[11:8]);
      end
      wait_drain();
      end_test();

      // with the target held off every accepted load stays in the FIFO
      begin_test("back-pressure");
      stall_i  = 1'b1;
      accepted = 0;
      while (gnt_o && accepted < 4 * FIFO_DEPTH)
      begin
         r_add = rand_word();
         r_ctl = rand_word();
         send_req(WEN_LOAD, r_add, '0, '0, r_ctl[ID_WIDTH-1:0]);
         accepted++;
      end
      if (gnt_o)
      begin
         $display("error at %0t: gnt_o never fell while the target was stalled", $time);
         error_count++;
      end
      if (accepted != FIFO_DEPTH)
      begin
         $display("[FAIL] %0t: %0d requests accepted, expected %0d", $time, accepted,
                  FIFO_DEPTH);
         error_count++;
      end
      stall_i = 1'b0;
      wait_drain();
      end_test();

      begin_test("random mixed traffic");
      rand_stall = 1'b1;
      for (i = 0; i < 500; i++)
      begin
         r_add  = rand_word();
         r_data = rand_word();
         r_ctl  = rand_word();
         send_req(r_ctl[0], r_add, r_data, r_ctl[4:1], r_ctl[8:5]);
         repeat (r_ctl[10:9]) next_cycle();
      end
      rand_stall = 1'b0;
      stall_i    = 1'b0;
      wait_drain();
      end_test();

      $display("tests run %0d, passed %0d, failed %0d, errors %0d", tests_run,
               tests_run - tests_failed, tests_failed, error_count);
      if (tests_failed == 0 && error_count == 0)
      begin
         $display("*** TEST PASSED ***");
      end
      else
      begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule
